/* Makefile */
# Verilator build and run for the debug control panel

VERILATOR ?= verilator
TOP       ?= tb_dcp
FILELIST  ?= src.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "CHECKS FAILED" $(LOG); then \
	    echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/tb_dcp.sv */
`default_nettype none

module tb_dcp;

    localparam int          DUMP_WORDS = 8;
    localparam int          REG_COUNT  = 32;
    localparam logic [31:0] seed_init  = 32'haa23_23e2;
    localparam logic [31:0] dm_mask    = 32'h5a5a_0f0f;
    localparam logic [31:0] rf_mult    = 32'h0101_0101;
    // ten full register dumps at a stall rate of one in three come to about 7000 cycles
    localparam int          max_cycles = 20000;

    logic        clk;
    logic        rstn;
    logic [7:0]  d_rx;
    logic        vld_rx;
    logic        rdy_rx;
    logic [7:0]  d_tx;
    logic        vld_tx;
    logic        rdy_tx;
    logic [31:0] addr;
    logic [31:0] dout_dm;
    logic [31:0] dout_rf;

    integer      seed;
    integer      bp_seed;
    logic        heavy_stall;
    logic [7:0]  exp_q[$];
    int          errors;
    int          checks;
    int          rx_errors;
    int          rx_checks;
    int          test_num;
    int          err_mark;
    int          cycles;

    dcp #(
        .DUMP_WORDS (DUMP_WORDS),
        .REG_COUNT  (REG_COUNT)
    ) uut (
        .clk     (clk),
        .rstn    (rstn),
        .d_rx    (d_rx),
        .vld_rx  (vld_rx),
        .rdy_rx  (rdy_rx),
        .d_tx    (d_tx),
        .vld_tx  (vld_tx),
        .rdy_tx  (rdy_tx),
        .addr    (addr),
        .dout_dm (dout_dm),
        .dout_rf (dout_rf)
    );

    // memory model read combinationally
    assign dout_dm = addr ^ dm_mask;
    assign dout_rf = addr * rf_mult;

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    function automatic logic [7:0] upper_digit(input logic [3:0] n);
        string s;
        s = "0123456789ABCDEF";
        return s.getc(int'(n));
    endfunction

    function automatic logic [7:0] lower_digit(input logic [3:0] n);
        string s;
        s = "0123456789abcdef";
        return s.getc(int'(n));
    endfunction

    // one printed line of eight digits then LF
    task automatic push_word(input logic [31:0] w);
        int i;
        for (i = 7; i >= 0; i--)
            exp_q.push_back(upper_digit(w[i*4 +: 4]));
        exp_q.push_back(dcp_pkg::ch_lf);
    endtask

    // entered and left at 1 time unit after a rising edge
    task automatic send_byte(input logic [7:0] b);
        repeat (rand_below(3))
        begin
            @(posedge clk);
            #1;
        end
        d_rx   = b;
        vld_rx = 1'b1;
        @(negedge clk);
        while (!rdy_rx)
            @(negedge clk);
        @(posedge clk);
        #1;
        vld_rx = 1'b0;
    endtask

    task automatic send_noise();
        int n;
        n = 1 + rand_below(3);
        repeat (n)
            send_byte((rand_below(2) == 1) ? dcp_pkg::ch_cr : dcp_pkg::ch_lf);
    endtask

    task automatic cmd_dump(input logic [31:0] a);
        int i;
        int n;
        for (i = 0; i < DUMP_WORDS; i++)
            push_word((a + 32'(i) * 32'd4) ^ dm_mask);
        send_byte(dcp_pkg::cmd_d);
        n = 1 + rand_below(3);
        repeat (n)
            send_byte(dcp_pkg::ch_sp);
        for (i = 7; i >= 0; i--)
            send_byte(lower_digit(a[i*4 +: 4]));
        send_byte(dcp_pkg::ch_cr);
    endtask

    task automatic cmd_regs();
        int i;
        for (i = 0; i < REG_COUNT; i++)
            push_word(32'(i) * rf_mult);
        send_byte(dcp_pkg::cmd_r);
    endtask

    task automatic cmd_bad();
        logic [7:0] c;
        c = dcp_pkg::cmd_d;
        while (c == dcp_pkg::cmd_d || c == dcp_pkg::cmd_r)
            c = 8'h21 + 8'(rand_below(94));
        exp_q.push_back(dcp_pkg::ch_qm);
        exp_q.push_back(dcp_pkg::ch_lf);
        send_byte(c);
    endtask

    // idle tail lets the receiver catch stray bytes
    task automatic wait_reply();
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (30)
            @(posedge clk);
        #1;
        // addr falls back to zero once the panel waits for a letter
        checks++;
        if (addr !== 32'd0)
        begin
            errors++;
            $display("CHECK FAILED at %0t: addr got %h expected 00000000", $time, addr);
        end
    endtask

    task automatic end_test(input string name);
        int total;
        total = errors + rx_errors;
        test_num++;
        $display("test %0d %s: %0d errors", test_num, name, total - err_mark);
        err_mark = total;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // transmit side, back-pressure and reply compare
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        logic [31:0] r;
        bp_seed = seed_init + 32'd1;
        rdy_tx  = 1'b0;
        forever
        begin
            @(posedge clk);
            #1;
            r = $random(bp_seed);
            // low one cycle in three, or two in three when stalling hard
            rdy_tx = heavy_stall ? (r % 32'd3 == 32'd0) : (r % 32'd3 != 32'd0);
        end
    end

    initial
    begin
        logic       prev_stall;
        logic [7:0] prev_d;
        logic [7:0] exp_byte;
        prev_stall = 1'b0;
        prev_d     = 8'd0;
        rx_errors  = 0;
        rx_checks  = 0;
        forever
        begin
            @(negedge clk);
            if (prev_stall)
            begin
                if (vld_tx !== 1'b1)
                begin
                    rx_errors++;
                    $display("vld_tx dropped at %0t before its byte was accepted", $time);
                end
                else if (d_tx !== prev_d)
                begin
                    rx_errors++;
                    $display("CHECK FAILED at %0t: d_tx got %h expected %h",
                             $time, d_tx, prev_d);
                end
            end
            if (vld_tx === 1'b1 && rdy_tx === 1'b1)
            begin
                if (exp_q.size() == 0)
                begin
                    rx_errors++;
                    $display("byte %h sent at %0t with no reply pending", d_tx, $time);
                end
                else
                begin
                    exp_byte = exp_q.pop_front();
                    rx_checks++;
                    if (d_tx !== exp_byte)
                    begin
                        rx_errors++;
                        $display("CHECK FAILED at %0t: d_tx got %h expected %h",
                                 $time, d_tx, exp_byte);
                    end
                end
            end
            prev_stall = (vld_tx === 1'b1) && (rdy_tx !== 1'b1);
            prev_d     = d_tx;
        end
    end

    initial
    begin
        cycles = 0;
        while (cycles < max_cycles)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run stopped after %0d cycles", cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        int   i;
        int   k;
        logic seen_rdy;
        seed        = seed_init;
        rstn        = 1'b0;
        d_rx        = 8'd0;
        vld_rx      = 1'b0;
        heavy_stall = 1'b0;
        errors      = 0;
        checks      = 0;
        test_num    = 0;
        err_mark    = 0;
        repeat (3)
            @(posedge clk);
        #1;
        rstn = 1'b1;

        // quiet after reset while the letter scan opens
        seen_rdy = 1'b0;
        for (i = 0; i < 20; i++)
        begin
            @(negedge clk);
            checks++;
            if (vld_tx !== 1'b0)
            begin
                errors++;
                $display("CHECK FAILED at %0t: vld_tx got %b expected 0", $time, vld_tx);
            end
            if (rdy_rx === 1'b1 && !seen_rdy)
            begin
                seen_rdy = 1'b1;
                if (i >= 3)
                begin
                    errors++;
                    $display("rdy_rx rose only %0d cycles after reset", i + 1);
                end
            end
        end
        if (!seen_rdy)
        begin
            errors++;
            $display("rdy_rx never went high after reset");
        end
        @(posedge clk);
        #1;
        end_test("reset idle");

        cmd_dump($random(seed));
        wait_reply();
        end_test("memory dump");

        cmd_regs();
        wait_reply();
        end_test("register dump");

        cmd_bad();
        cmd_dump($random(seed));
        wait_reply();
        end_test("unknown letter");

        heavy_stall = 1'b1;
        cmd_dump($random(seed));
        wait_reply();
        heavy_stall = 1'b0;
        end_test("back-pressure");

        for (i = 0; i < 10; i++)
        begin
            if (rand_below(2) == 1)
                send_noise();
            k = rand_below(3);
            if (k == 0)
                cmd_dump($random(seed));
            else if (k == 1)
                cmd_regs();
            else
                cmd_bad();
        end
        wait_reply();
        end_test("command sequence");

        $display("tests %0d, checks %0d, errors %0d",
                 test_num, checks + rx_checks, errors + rx_errors);
        if (errors + rx_errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/dcp.sv */
`default_nettype none

module dcp #(
    parameter int DUMP_WORDS = 8,
    parameter int REG_COUNT  = 32
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic [7:0]  d_rx,
    input  logic        vld_rx,
    output logic        rdy_rx,
    output logic [7:0]  d_tx,
    output logic        vld_tx,
    input  logic        rdy_tx,
    output logic [31:0] addr,
    input  logic [31:0] dout_dm,
    input  logic [31:0] dout_rf
);

    localparam logic [2:0] st_init     = 3'd0;
    localparam logic [2:0] st_scan     = 3'd1;
    localparam logic [2:0] st_start    = 3'd2;
    localparam logic [2:0] st_wait     = 3'd3;
    localparam logic [2:0] st_bad_req  = 3'd4;
    localparam logic [2:0] st_bad_wait = 3'd5;

    logic [2:0]     state;
    dcp_pkg::mode_e mode;
    logic           disp_scan_req;
    logic           disp_prn_req;
    logic           bad_lf;
    logic           child_done;
    logic           start_d;
    logic           start_r;
    logic           done_d;
    logic           done_r;
    logic [31:0]    addr_d;
    logic [31:0]    addr_r;

    scan_if  scan_bus ();
    scan_if  scan_d ();
    print_if prn_bus ();
    print_if prn_d ();
    print_if prn_r ();

    dcp_scan u_scan (
        .clk    (clk),
        .rstn   (rstn),
        .d_rx   (d_rx),
        .vld_rx (vld_rx),
        .rdy_rx (rdy_rx),
        .scan   (scan_bus)
    );

    dcp_print u_print (
        .clk    (clk),
        .rstn   (rstn),
        .d_tx   (d_tx),
        .vld_tx (vld_tx),
        .rdy_tx (rdy_tx),
        .prn    (prn_bus)
    );

    dcp_cmd_d #(
        .DUMP_WORDS (DUMP_WORDS)
    ) u_cmd_d (
        .clk     (clk),
        .rstn    (rstn),
        .start   (start_d),
        .done    (done_d),
        .scan    (scan_d),
        .prn     (prn_d),
        .addr    (addr_d),
        .dout_dm (dout_dm)
    );

    dcp_cmd_r #(
        .REG_COUNT (REG_COUNT)
    ) u_cmd_r (
        .clk     (clk),
        .rstn    (rstn),
        .start   (start_r),
        .done    (done_r),
        .prn     (prn_r),
        .addr    (addr_r),
        .dout_rf (dout_rf)
    );

    ////////////////////////////////////////////////////////////////////////////
    // dispatcher
    ////////////////////////////////////////////////////////////////////////////

    assign start_d = (state == st_start) && (mode == dcp_pkg::mode_d);
    assign start_r = (state == st_start) && (mode == dcp_pkg::mode_r);

    always_comb
    begin
        case (mode)
            dcp_pkg::mode_d:   child_done = done_d;
            dcp_pkg::mode_r:   child_done = done_r;
            default:           child_done = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state         <= st_init;
            mode          <= dcp_pkg::mode_idle;
            disp_scan_req <= 1'b0;
            disp_prn_req  <= 1'b0;
            bad_lf        <= 1'b0;
        end
        else
        begin
            case (state)
                st_init:
                begin
                    disp_scan_req <= 1'b1;
                    state         <= st_scan;
                end
                st_scan:
                    if (scan_bus.ack)
                    begin
                        disp_scan_req <= 1'b0;
                        state         <= st_start;
                        case (scan_bus.data.c.ch)
                            dcp_pkg::cmd_d: mode <= dcp_pkg::mode_d;
                            dcp_pkg::cmd_r: mode <= dcp_pkg::mode_r;
                            default:        mode <= dcp_pkg::mode_bad;
                        endcase
                    end
                // unknown letter is answered here, not by a child
                st_start:
                    if (mode == dcp_pkg::mode_bad)
                    begin
                        disp_prn_req <= 1'b1;
                        bad_lf       <= 1'b0;
                        state        <= st_bad_wait;
                    end
                    else
                        state <= st_wait;
                st_wait:
                    if (child_done)
                    begin
                        mode  <= dcp_pkg::mode_idle;
                        state <= st_init;
                    end
                st_bad_req:
                begin
                    disp_prn_req <= 1'b1;
                    state        <= st_bad_wait;
                end
                st_bad_wait:
                    if (prn_bus.ack)
                    begin
                        disp_prn_req <= 1'b0;
                        if (bad_lf)
                        begin
                            mode  <= dcp_pkg::mode_idle;
                            state <= st_init;
                        end
                        else
                        begin
                            bad_lf <= 1'b1;
                            state  <= st_bad_req;
                        end
                    end
                default:
                    state <= st_init;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // owner select
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        scan_bus.req  = 1'b0;
        scan_bus.kind = dcp_pkg::io_char;
        prn_bus.req   = 1'b0;
        prn_bus.kind  = dcp_pkg::io_char;
        prn_bus.data  = {24'd0, (bad_lf ? dcp_pkg::ch_lf : dcp_pkg::ch_qm)};
        addr          = 32'd0;
        case (mode)
            dcp_pkg::mode_idle:
                scan_bus.req = disp_scan_req;
            dcp_pkg::mode_d:
            begin
                scan_bus.req  = scan_d.req;
                scan_bus.kind = scan_d.kind;
                prn_bus.req   = prn_d.req;
                prn_bus.kind  = prn_d.kind;
                prn_bus.data  = prn_d.data;
                addr          = addr_d;
            end
            dcp_pkg::mode_r:
            begin
                prn_bus.req  = prn_r.req;
                prn_bus.kind = prn_r.kind;
                prn_bus.data = prn_r.data;
                addr         = addr_r;
            end
            default:
                prn_bus.req = disp_prn_req;
        endcase
    end

    // acks reach only the current owner
    assign scan_d.ack  = scan_bus.ack & (mode == dcp_pkg::mode_d);
    assign scan_d.flag = scan_bus.flag;
    assign scan_d.data = scan_bus.data;
    assign prn_d.ack   = prn_bus.ack & (mode == dcp_pkg::mode_d);
    assign prn_r.ack   = prn_bus.ack & (mode == dcp_pkg::mode_r);

    // a child is picked only by a letter the scanner just returned
    mode_from_ack: assert property (@(posedge clk) disable iff (!rstn)
        (mode != dcp_pkg::mode_idle && $past(mode) == dcp_pkg::mode_idle)
            |-> $past(scan_bus.ack));

    idle_after_done: assert property (@(posedge clk) disable iff (!rstn)
        child_done |=> (mode == dcp_pkg::mode_idle));

endmodule

`default_nettype wire

/* rtl/dcp_cmd_d.sv */
`default_nettype none

module dcp_cmd_d #(
    parameter int DUMP_WORDS = 8
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic        start,
    output logic        done,
    scan_if.client      scan,
    print_if.client     prn,
    output logic [31:0] addr,
    input  logic [31:0] dout_dm
);

    localparam int CW = $clog2(DUMP_WORDS + 1);

    localparam logic [2:0] st_idle   = 3'd0;
    localparam logic [2:0] st_scan   = 3'd1;
    localparam logic [2:0] st_read   = 3'd2;
    localparam logic [2:0] st_hex    = 3'd3;
    localparam logic [2:0] st_lf_req = 3'd4;
    localparam logic [2:0] st_lf     = 3'd5;

    logic [2:0]    state;
    logic [CW-1:0] cnt;
    logic [31:0]   word;
    logic          last;
    logic          is_lf;

    assign last      = (cnt == CW'(DUMP_WORDS - 1));
    assign is_lf     = (state == st_lf_req) || (state == st_lf);
    assign scan.kind = dcp_pkg::io_hex;
    assign prn.kind  = is_lf ? dcp_pkg::io_char : dcp_pkg::io_hex;
    assign prn.data  = is_lf ? {24'd0, dcp_pkg::ch_lf} : word;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state    <= st_idle;
            scan.req <= 1'b0;
            prn.req  <= 1'b0;
            done     <= 1'b0;
            cnt      <= '0;
            addr     <= 32'd0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                st_idle:
                    if (start)
                    begin
                        scan.req <= 1'b1;
                        state    <= st_scan;
                    end
                // start address ends on CR
                st_scan:
                    if (scan.ack)
                    begin
                        scan.req <= 1'b0;
                        addr     <= scan.data.value;
                        cnt      <= '0;
                        state    <= st_read;
                    end
                st_read:
                begin
                    prn.req <= 1'b1;
                    state   <= st_hex;
                end
                st_hex:
                    if (prn.ack)
                    begin
                        prn.req <= 1'b0;
                        state   <= st_lf_req;
                    end
                st_lf_req:
                begin
                    prn.req <= 1'b1;
                    state   <= st_lf;
                end
                st_lf:
                    if (prn.ack)
                    begin
                        prn.req <= 1'b0;
                        addr    <= addr + 32'd4;
                        cnt     <= cnt + CW'(1);
                        if (last)
                        begin
                            done  <= 1'b1;
                            state <= st_idle;
                        end
                        else
                            state <= st_read;
                    end
                default:
                    state <= st_idle;
            endcase
        end
    end

    // addr was set a cycle earlier
    always_ff @(posedge clk)
    begin
        if (state == st_read)
            word <= dout_dm;
    end

endmodule

`default_nettype wire

/* rtl/dcp_cmd_r.sv */
`default_nettype none

module dcp_cmd_r #(
    parameter int REG_COUNT = 32
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic        start,
    output logic        done,
    print_if.client     prn,
    output logic [31:0] addr,
    input  logic [31:0] dout_rf
);

    localparam int IW = $clog2(REG_COUNT + 1);

    localparam logic [2:0] st_idle   = 3'd0;
    localparam logic [2:0] st_read   = 3'd1;
    localparam logic [2:0] st_hex    = 3'd2;
    localparam logic [2:0] st_lf_req = 3'd3;
    localparam logic [2:0] st_lf     = 3'd4;

    logic [2:0]    state;
    logic [IW-1:0] idx;
    logic [31:0]   word;
    logic          is_lf;

    assign addr     = 32'(idx);
    assign is_lf    = (state == st_lf_req) || (state == st_lf);
    assign prn.kind = is_lf ? dcp_pkg::io_char : dcp_pkg::io_hex;
    assign prn.data = is_lf ? {24'd0, dcp_pkg::ch_lf} : word;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state   <= st_idle;
            prn.req <= 1'b0;
            done    <= 1'b0;
            idx     <= '0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                st_idle:
                    if (start)
                    begin
                        idx   <= '0;
                        state <= st_read;
                    end
                st_read:
                begin
                    prn.req <= 1'b1;
                    state   <= st_hex;
                end
                st_hex:
                    if (prn.ack)
                    begin
                        prn.req <= 1'b0;
                        state   <= st_lf_req;
                    end
                st_lf_req:
                begin
                    prn.req <= 1'b1;
                    state   <= st_lf;
                end
                st_lf:
                    if (prn.ack)
                    begin
                        prn.req <= 1'b0;
                        if (idx == IW'(REG_COUNT - 1))
                        begin
                            done  <= 1'b1;
                            state <= st_idle;
                        end
                        else
                        begin
                            idx   <= idx + IW'(1);
                            state <= st_read;
                        end
                    end
                default:
                    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == st_read)
            word <= dout_rf;
    end

endmodule

`default_nettype wire

/* rtl/dcp_if.sv */
`default_nettype none

// link between a client and the byte scanner
interface scan_if;
    logic                req;
    dcp_pkg::io_type_e   kind;
    logic                ack;
    logic                flag;
    dcp_pkg::scan_word_u data;

    modport client (output req, output kind, input ack, input flag, input data);
    modport scanner (input req, input kind, output ack, output flag, output data);
endinterface

// link between a client and the byte printer
interface print_if;
    logic              req;
    dcp_pkg::io_type_e kind;
    logic              ack;
    logic [31:0]       data;

    modport client (output req, output kind, output data, input ack);
    modport printer (input req, input kind, input data, output ack);
endinterface

`default_nettype wire

/* rtl/dcp_pkg.sv */
`default_nettype none

package dcp_pkg;

    // command letters
    localparam logic [7:0] cmd_d = 8'h44;
    localparam logic [7:0] cmd_r = 8'h52;

    // ascii bytes seen on the serial link
    localparam logic [7:0] ch_lf = 8'h0a;
    localparam logic [7:0] ch_cr = 8'h0d;
    localparam logic [7:0] ch_sp = 8'h20;
    localparam logic [7:0] ch_qm = 8'h3f;

    // one character or one hex word per transfer
    typedef enum logic {
        io_char,
        io_hex
    } io_type_e;

    // dispatcher's current child
    typedef enum logic [1:0] {
        mode_idle,
        mode_d,
        mode_r,
        mode_bad
    } mode_e;

    typedef struct packed {
        logic [23:0] pad;
        logic [7:0]  ch;
    } scan_char_s;

    // scanner result as a command letter or a 32-bit hex value
    typedef union packed {
        logic [31:0] value;
        scan_char_s  c;
    } scan_word_u;

endpackage

`default_nettype wire

/* rtl/dcp_print.sv */
`default_nettype none

module dcp_print (
    input  logic       clk,
    input  logic       rstn,
    output logic [7:0] d_tx,
    output logic       vld_tx,
    input  logic       rdy_tx,
    print_if.printer   prn
);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_send = 2'd1;
    localparam logic [1:0] st_ack  = 2'd2;

    logic [1:0]        state;
    logic [31:0]       word;
    logic [2:0]        digit;
    dcp_pkg::io_type_e kind;
    logic              last;

    // upper-case digits only
    function automatic logic [7:0] hex_ascii(input logic [3:0] n);
        if (n < 4'd10)
            return 8'h30 + {4'd0, n};
        else
            return 8'h37 + {4'd0, n};
    endfunction

    assign vld_tx  = (state == st_send);
    assign d_tx    = (kind == dcp_pkg::io_char) ? word[7:0] : hex_ascii(word[31:28]);
    assign last    = (kind == dcp_pkg::io_char) || (digit == 3'd7);
    assign prn.ack = (state == st_ack);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state <= st_idle;
        end
        else
        begin
            case (state)
                st_idle:
                    if (prn.req)
                        state <= st_send;
                st_send:
                    if (rdy_tx && last)
                        state <= st_ack;
                default:
                    state <= st_idle;
            endcase
        end
    end

    // word shifts left one nibble per accepted digit
    always_ff @(posedge clk)
    begin
        if (state == st_idle)
        begin
            word  <= prn.data;
            kind  <= prn.kind;
            digit <= 3'd0;
        end
        else if ((state == st_send) && rdy_tx && !last)
        begin
            word  <= {word[27:0], 4'd0};
            digit <= digit + 3'd1;
        end
    end

    // stalled byte must not change under the receiver
    tx_hold: assert property (@(posedge clk) disable iff (!rstn)
        (vld_tx && !rdy_tx) |=> $stable(d_tx));

endmodule

`default_nettype wire

/* rtl/dcp_scan.sv */
`default_nettype none

module dcp_scan (
    input  logic       clk,
    input  logic       rstn,
    input  logic [7:0] d_rx,
    input  logic       vld_rx,
    output logic       rdy_rx,
    scan_if.scanner    scan
);

    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_collect = 2'd1;
    localparam logic [1:0] st_done    = 2'd2;

    logic [1:0]          state;
    dcp_pkg::scan_word_u acc;
    logic                started;
    logic                term_cr;
    logic [4:0]          hex;
    logic                take;
    logic                is_blank;
    logic                finish;

    // valid bit above the nibble for either case
    function automatic logic [4:0] hex_digit(input logic [7:0] b);
        logic [4:0] r;
        r = 5'd0;
        if (b >= 8'h30 && b <= 8'h39)
            r = {1'b1, b[3:0]};
        else if ((b >= 8'h41 && b <= 8'h46) || (b >= 8'h61 && b <= 8'h66))
            r = {1'b1, b[3:0] + 4'd9};
        return r;
    endfunction

    assign rdy_rx   = (state == st_collect);
    assign take     = rdy_rx & vld_rx;
    assign hex      = hex_digit(d_rx);
    assign is_blank = (d_rx == dcp_pkg::ch_sp) || (d_rx == dcp_pkg::ch_cr) ||
                      (d_rx == dcp_pkg::ch_lf);

    // byte that closes the current request
    always_comb
    begin
        if (scan.kind == dcp_pkg::io_char)
            finish = !is_blank;
        else
            finish = !hex[4] && !((d_rx == dcp_pkg::ch_sp) && !started);
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state <= st_idle;
        end
        else
        begin
            case (state)
                st_idle:
                    if (scan.req)
                        state <= st_collect;
                st_collect:
                    if (take && finish)
                        state <= st_done;
                default:
                    state <= st_idle;
            endcase
        end
    end

    // accumulator cleared while no request is open
    always_ff @(posedge clk)
    begin
        if (state == st_idle)
        begin
            acc.value <= 32'd0;
            started   <= 1'b0;
            term_cr   <= 1'b0;
        end
        else if (take)
        begin
            if (scan.kind == dcp_pkg::io_char)
            begin
                acc.c.pad <= 24'd0;
                acc.c.ch  <= d_rx;
            end
            else if (hex[4])
            begin
                acc.value <= {acc.value[27:0], hex[3:0]};
                started   <= 1'b1;
            end
            term_cr <= (d_rx == dcp_pkg::ch_cr);
        end
    end

    assign scan.ack  = (state == st_done);
    assign scan.flag = term_cr;
    assign scan.data = acc;

    // client drops req right after ack so no second request follows
    ack_single: assert property (@(posedge clk) disable iff (!rstn)
        scan.ack |=> !scan.req);

endmodule

`default_nettype wire

/* src.f */
rtl/dcp_pkg.sv
rtl/dcp_if.sv
rtl/dcp_scan.sv
rtl/dcp_print.sv
rtl/dcp_cmd_d.sv
rtl/dcp_cmd_r.sv
rtl/dcp.sv
bench/tb_dcp.sv
